//--- cpu.f
hdl/rv32_pkg.sv
hdl/mem_pkg.sv
hdl/alu.sv
hdl/decoder.sv
hdl/reg_file.sv
hdl/mem_ctrl.sv
hdl/core_seq.sv
hdl/cpu.sv
tb/tb_cpu.sv

//--- Makefile
# Verilator simulation of the rv32i core

.PHONY: build run clean

build:
	verilator --binary --timing --assert --top-module tb_cpu -f cpu.f

run: build
	@out="$$(./obj_dir/Vtb_cpu)"; echo "$$out"; echo "$$out" | grep -qF '*** PASSED ***'

clean:
	rm -rf obj_dir

//--- tb/tb_cpu.sv
// rv32i core testbench with byte memory model and program generator
// reference ISS and store checker
`timescale 1ns/1ps
`default_nettype none

module tb_cpu;

    import mem_pkg::*;

    logic  clk = 1'b0;
    logic  rst_n;
    logic  rdy;
    byte_t mem_din;
    byte_t mem_dout;
    addr_t mem_a;
    logic  mem_wr;
    logic  halt;

    // 128 KB behind the bus
    logic [7:0]  mem [0:131071];
    logic [31:0] lfsr;
    logic [31:0] prog_pc;
    // expected stores from the ISS in program order
    logic [31:0] exp_addr [$];
    logic [31:0] exp_data [$];

    // bus model state
    int          ncyc;
    int          exp_idx;
    int          post_cnt;
    addr_t       ret_a;
    addr_t       prev_a;
    logic        prev_wr;
    logic [1:0]  lane;
    logic [31:0] wr_word;
    logic        stop_seen;
    logic        halt_seen;
    logic        run_done;

    cpu #(
        .RESET_PC (32'h0)
    ) cpu_i (
        .clk_in     (clk),
        .i_rst_n    (rst_n),
        .i_rdy      (rdy),
        .i_mem_din  (mem_din),
        .o_mem_dout (mem_dout),
        .o_mem_a    (mem_a),
        .o_mem_wr   (mem_wr),
        .o_halt     (halt)
    );

    always #20 clk = ~clk;

    // galois form with taps x^32+x^22+x^2+x+1
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    // x1..x7 only
    function automatic logic [4:0] pick_reg();
        return 5'(rand_bits(3) % 7) + 5'd1;
    endfunction

    // index 0..5 is add sub and or xor slt
    function automatic logic [2:0] alu_f3(input int k);
        case (k)
            2:       return 3'b111;
            3:       return 3'b110;
            4:       return 3'b100;
            5:       return 3'b010;
            default: return 3'b000;
        endcase
    endfunction

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'h33};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    // sw only
    function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'h23};
    endfunction

    function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
    endfunction

    // lui
    function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd);
        return {imm, rd, 7'h37};
    endfunction

    task automatic emit(input logic [31:0] ins);
        {mem[prog_pc[16:0] + 17'd3], mem[prog_pc[16:0] + 17'd2],
         mem[prog_pc[16:0] + 17'd1], mem[prog_pc[16:0]]} = ins;
        prog_pc = prog_pc + 32'd4;
    endtask

    function automatic logic [31:0] image_word(input logic [31:0] a);
        logic [16:0] b;
        b = a[16:0];
        return {mem[b + 17'd3], mem[b + 17'd2], mem[b + 17'd1], mem[b]};
    endfunction

    task automatic build_program();
        int          sel;
        logic [11:0] imm;
        // background folds every address bit into the byte
        for (int i = 0; i < 131072; i++) begin
            mem[i] = 8'(i ^ (i >> 8) ^ (i >> 16));
        end
        prog_pc = '0;
        // random seeds in x1..x7
        for (int r = 1; r < 8; r++) begin
            emit(enc_u(20'(rand_bits(20)), 5'(r)));
            emit(enc_i(12'(rand_bits(12)), 5'(r), 3'b000, 5'(r), 7'h13));
        end
        // 0..5 register forms and 6..10 immediate forms
        for (int n = 0; n < 40; n++) begin
            sel = int'(rand_bits(4) % 11);
            imm = 12'(rand_bits(12));
            if (sel < 6) begin
                emit(enc_r((sel == 1) ? 7'h20 : 7'h00, pick_reg(), pick_reg(),
                           alu_f3(sel), pick_reg()));
            end else begin
                emit(enc_i(imm, pick_reg(), alu_f3(sel - 5), pick_reg(), 7'h13));
            end
        end
        // x8 = data area at 64 KB
        emit(enc_u(20'h00010, 5'd8));
        // store, load back into x9, store x9 again
        emit(enc_s(12'h000, 5'd3, 5'd8));
        emit(enc_i(12'h000, 5'd8, 3'b010, 5'd9, 7'h03));
        emit(enc_s(12'h004, 5'd9, 5'd8));
        // beq on equal operands skips the next store
        emit(enc_b(13'h008, 5'd9, 5'd9, 3'b000));
        emit(enc_s(12'h008, 5'd1, 5'd8));
        emit(enc_s(12'h00c, 5'd2, 5'd8));
        // bne on equal operands falls through
        emit(enc_b(13'h008, 5'd9, 5'd9, 3'b001));
        emit(enc_s(12'h010, 5'd4, 5'd8));
        emit(enc_s(12'h014, 5'd5, 5'd8));
        // register dump
        for (int r = 1; r < 8; r++) begin
            emit(enc_s(12'(32'h40 + 4 * r), 5'(r), 5'd8));
        end
        // x12 points at the i/o window and the stop port
        emit(enc_u(20'h00030, 5'd12));
        emit(enc_s(12'h004, 5'd9, 5'd12));
    endtask

    // instruction set model filling the expected store list
    // returns the number of executed instructions
    function automatic int run_iss();
        logic [31:0] x [0:31];
        logic [31:0] dm [logic [31:0]];
        logic [31:0] pc;
        logic [31:0] npc;
        logic [31:0] ins;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] ea;
        logic [31:0] v;
        logic [2:0]  f3;
        int          steps;
        logic        done;
        for (int i = 0; i < 32; i++) begin
            x[i] = '0;
        end
        pc = '0;
        steps = 0;
        done = 1'b0;
        while (!done && steps < 1000) begin
            ins = image_word(pc);
            f3 = ins[14:12];
            a = x[ins[19:15]];
            b = (ins[6:0] == 7'h13) ? {{20{ins[31]}}, ins[31:20]} : x[ins[24:20]];
            npc = pc + 32'd4;
            case (ins[6:0])
                7'h33, 7'h13: begin
                    case (f3)
                        3'b000:  v = (ins[6:0] == 7'h33 && ins[30]) ? a - b : a + b;
                        3'b010:  v = {31'b0, $signed(a) < $signed(b)};
                        3'b100:  v = a ^ b;
                        3'b110:  v = a | b;
                        default: v = a & b;
                    endcase
                    x[ins[11:7]] = v;
                end
                7'h37: x[ins[11:7]] = {ins[31:12], 12'b0};
                7'h03: begin
                    ea = a + {{20{ins[31]}}, ins[31:20]};
                    x[ins[11:7]] = dm.exists(ea) ? dm[ea] : image_word(ea);
                end
                7'h23: begin
                    ea = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
                    dm[ea] = x[ins[24:20]];
                    exp_addr.push_back(ea);
                    exp_data.push_back(x[ins[24:20]]);
                    done = (ea == IO_STOP_ADDR);
                end
                7'h63: begin
                    // beq taken on equal and bne on different
                    if ((a == x[ins[24:20]]) == (f3 == 3'b000)) begin
                        npc = pc + {{19{ins[31]}}, ins[31], ins[7], ins[30:25],
                                    ins[11:8], 1'b0};
                    end
                end
                default: done = 1'b1;
            endcase
            x[0] = '0;
            pc = npc;
            steps++;
        end
        return steps;
    endfunction

    task automatic fail_now(input string why);
        $display("%s", why);
        $display("*** FAILED ***");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            fail_now($sformatf("[ERROR] %s: got 0x%08h, expected 0x%08h", name, got, exp));
        end
    endtask

    // one bus cycle on the falling edge
    task automatic serve_bus();
        logic [31:0] waddr;
        // nothing may move across a stalled cycle
        if (!rdy) begin
            check_value("o_mem_a", mem_a, prev_a);
            check_value("o_mem_wr", 32'(mem_wr), 32'(prev_wr));
        end
        if (halt && !stop_seen) begin
            fail_now("o_halt rose before the stop store was written");
        end
        if (stop_seen && mem_wr) begin
            fail_now("o_mem_wr pulsed again after the stop store");
        end
        prev_a = mem_a;
        prev_wr = mem_wr;
        // byte for the address of the last active cycle
        mem_din = mem[ret_a[16:0]];
        // about one cycle in four stalled
        rdy = (rand_bits(2) != 0);
        if (rdy) begin
            ret_a = mem_a;
            if (mem_wr) begin
                if (mem_a[17:16] != IO_SEL) begin
                    mem[mem_a[16:0]] = mem_dout;
                end
                check_value("o_mem_a lane", 32'(mem_a[1:0]), 32'(lane));
                wr_word[8*mem_a[1:0] +: 8] = mem_dout;
                lane = lane + 2'd1;
                if (mem_a[1:0] == 2'd3) begin
                    waddr = {mem_a[31:2], 2'b00};
                    check_value("o_mem_a word", waddr, exp_addr[exp_idx]);
                    check_value("o_mem_dout word", wr_word, exp_data[exp_idx]);
                    exp_idx++;
                    stop_seen = (waddr == IO_STOP_ADDR);
                end
            end
        end
        if (stop_seen) begin
            post_cnt++;
            halt_seen = halt_seen | halt;
            if (!halt_seen && post_cnt > 20) begin
                fail_now("o_halt did not rise after the stop store");
            end
            // quiet period after halt
            if (halt_seen && post_cnt > 40) begin
                run_done = 1'b1;
            end
        end
    endtask

    // reset sequence and the bus model
    always @(negedge clk) begin
        ncyc = ncyc + 1;
        if (ncyc <= 3) begin
            check_value("o_mem_wr", 32'(mem_wr), 32'h0);
            check_value("o_halt", 32'(halt), 32'h0);
        end
        if (ncyc == 2) begin
            rst_n = 1'b1;
        end
        // first fetch starts at the reset pc
        if (ncyc == 3) begin
            check_value("o_mem_a", mem_a, 32'h0);
        end
        if (ncyc >= 3 && !run_done) begin
            serve_bus();
        end
    end

    initial begin
        int iss_steps;
        int limit;
        int waited;
        rst_n = 1'b0;
        rdy = 1'b1;
        mem_din = '0;
        lfsr = 32'hdf157f2d;
        ncyc = 0;
        exp_idx = 0;
        post_cnt = 0;
        ret_a = '0;
        prev_a = '0;
        prev_wr = 1'b0;
        lane = '0;
        wr_word = '0;
        stop_seen = 1'b0;
        halt_seen = 1'b0;
        run_done = 1'b0;
        build_program();
        iss_steps = run_iss();
        // 20 cycles per instruction and x4 for stalls
        limit = iss_steps * 20 * 4 + 64;
        waited = 0;
        while (!run_done && waited < limit) begin
            @(posedge clk);
            waited++;
        end
        if (run_done) begin
            $display("*** PASSED ***");
            $finish;
        end else begin
            fail_now($sformatf("timeout: run not finished after %0d cycles", limit));
        end
    end

endmodule

`default_nettype wire

//--- hdl/cpu.sv
// rv32i core top level
// memory controller, sequencer, decoder, register file and alu
`timescale 1ns/1ps
`default_nettype none

module cpu #(
    // address of the first fetch
    parameter mem_pkg::addr_t RESET_PC = '0
) (
    input  logic            clk_in,
    input  logic            i_rst_n,
    // freezes the whole core while low
    input  logic            i_rdy,
    input  mem_pkg::byte_t  i_mem_din,
    output mem_pkg::byte_t  o_mem_dout,
    output mem_pkg::addr_t  o_mem_a,
    output logic            o_mem_wr,
    output logic            o_halt
);

    import rv32_pkg::*;
    import mem_pkg::*;

    // sequencer to memory controller handshake
    logic     req;
    logic     we;
    addr_t    addr;
    word_t    wdata;
    logic     ack;
    word_t    rdata;

    // decoded instruction
    word_t    inst;
    opcode_t  opcode;
    funct3_t  funct3;
    reg_idx_t rd;
    reg_idx_t rs1;
    reg_idx_t rs2;
    word_t    imm;
    alu_op_e  alu_op;
    logic     use_imm;

    // register file and alu
    word_t    rs1_val;
    word_t    rs2_val;
    logic     rf_we;
    word_t    rf_wdata;
    word_t    alu_result;
    logic     zero;

    mem_ctrl u_mem_ctrl (
        .clk_in     (clk_in),
        .i_rst_n    (i_rst_n),
        .i_rdy      (i_rdy),
        .i_req      (req),
        .i_we       (we),
        .i_addr     (addr),
        .i_wdata    (wdata),
        .o_ack      (ack),
        .o_rdata    (rdata),
        .i_mem_din  (i_mem_din),
        .o_mem_dout (o_mem_dout),
        .o_mem_a    (o_mem_a),
        .o_mem_wr   (o_mem_wr)
    );

    core_seq #(
        .RESET_PC (RESET_PC)
    ) u_core_seq (
        .clk_in       (clk_in),
        .i_rst_n      (i_rst_n),
        .i_rdy        (i_rdy),
        .o_req        (req),
        .o_we         (we),
        .o_addr       (addr),
        .o_wdata      (wdata),
        .i_ack        (ack),
        .i_rdata      (rdata),
        .o_inst       (inst),
        .i_opcode     (opcode),
        .i_funct3     (funct3),
        .i_imm        (imm),
        .i_alu_result (alu_result),
        .i_zero       (zero),
        .i_rs2_val    (rs2_val),
        .o_rf_we      (rf_we),
        .o_rf_wdata   (rf_wdata),
        .o_halt       (o_halt)
    );

    decoder u_decoder (
        .i_inst    (inst),
        .o_opcode  (opcode),
        .o_funct3  (funct3),
        .o_rd      (rd),
        .o_rs1     (rs1),
        .o_rs2     (rs2),
        .o_imm     (imm),
        .o_alu_op  (alu_op),
        .o_use_imm (use_imm)
    );

    reg_file u_reg_file (
        .clk_in    (clk_in),
        .i_rst_n   (i_rst_n),
        .i_rdy     (i_rdy),
        .i_rs1     (rs1),
        .i_rs2     (rs2),
        .o_rs1_val (rs1_val),
        .o_rs2_val (rs2_val),
        .i_we      (rf_we),
        .i_rd      (rd),
        .i_wdata   (rf_wdata)
    );

    alu u_alu (
        .i_op      (alu_op),
        .i_a       (rs1_val),
        .i_b       (rs2_val),
        .i_imm     (imm),
        .i_use_imm (use_imm),
        .o_result  (alu_result),
        .o_zero    (zero)
    );

endmodule

`default_nettype wire

//--- hdl/core_seq.sv
// sequencer FSM with pc, instruction register and result latch
// branch resolve and stop-address detection
`timescale 1ns/1ps
`default_nettype none

module core_seq #(
    parameter mem_pkg::addr_t RESET_PC = '0
) (
    input  logic              clk_in,
    input  logic              i_rst_n,
    input  logic              i_rdy,
    // handshake to the memory controller
    output logic              o_req,
    output logic              o_we,
    output mem_pkg::addr_t    o_addr,
    output rv32_pkg::word_t   o_wdata,
    input  logic              i_ack,
    input  rv32_pkg::word_t   i_rdata,
    // decoder
    output rv32_pkg::word_t   o_inst,
    input  rv32_pkg::opcode_t i_opcode,
    input  rv32_pkg::funct3_t i_funct3,
    input  rv32_pkg::word_t   i_imm,
    // alu
    input  rv32_pkg::word_t   i_alu_result,
    input  logic              i_zero,
    // register file
    input  rv32_pkg::word_t   i_rs2_val,
    output logic              o_rf_we,
    output rv32_pkg::word_t   o_rf_wdata,
    output logic              o_halt
);

    import rv32_pkg::*;
    import mem_pkg::*;

    typedef enum logic [2:0] {
        FETCH_REQ,
        FETCH_WAIT,
        EXEC,
        MEM_REQ,
        MEM_WAIT,
        WB,
        HALT
    } state_e;

    state_e state;
    addr_t  pc;
    word_t  ir;
    // alu result, then load data for loads
    word_t  res;
    logic   br_taken;

    logic   is_branch;
    logic   is_load;
    logic   is_store;
    logic   writes_rd;
    logic   stop_hit;

    assign is_branch = (i_opcode == OPC_BRANCH);
    assign is_load   = (i_opcode == OPC_LOAD);
    assign is_store  = (i_opcode == OPC_STORE);
    assign writes_rd = (i_opcode == OPC_OP) || (i_opcode == OPC_OP_IMM) ||
                       (i_opcode == OPC_LUI) || is_load;

    // i/o window, then the offset of the stop port
    assign stop_hit = (res[MEM_ADDR_BITS:MEM_ADDR_BITS-1] == IO_SEL) &&
                      (res[MEM_ADDR_BITS-2:0] == IO_STOP_ADDR[MEM_ADDR_BITS-2:0]);

    // req held through the wait states only
    assign o_req  = (state == FETCH_WAIT) || (state == MEM_WAIT);
    assign o_we   = (state == MEM_WAIT) && is_store;
    assign o_addr = ((state == MEM_REQ) || (state == MEM_WAIT)) ? res : pc;
    // ir and registers are stable until wb
    assign o_wdata = i_rs2_val;

    assign o_inst     = ir;
    assign o_rf_we    = (state == WB) && writes_rd;
    assign o_rf_wdata = res;
    assign o_halt     = (state == HALT);

    always_ff @(posedge clk_in) begin
        if (!i_rst_n) begin
            state    <= FETCH_REQ;
            pc       <= RESET_PC;
            br_taken <= 1'b0;
        end else if (i_rdy) begin
            case (state)
                // previous ack must be down first
                FETCH_REQ: if (!i_ack) state <= FETCH_WAIT;
                FETCH_WAIT: if (i_ack) state <= EXEC;
                EXEC: begin
                    br_taken <= is_branch && ((i_funct3 == F3_BEQ) ? i_zero : !i_zero);
                    state    <= (is_load || is_store) ? MEM_REQ : WB;
                end
                MEM_REQ: if (!i_ack) state <= MEM_WAIT;
                MEM_WAIT: begin
                    // stop store finishes its bytes, then park
                    if (i_ack) begin
                        state <= (is_store && stop_hit) ? HALT : WB;
                    end
                end
                WB: begin
                    pc    <= br_taken ? pc + i_imm : pc + addr_t'(BYTES_PER_WORD);
                    state <= FETCH_REQ;
                end
                default: state <= HALT;
            endcase
        end
    end

    always_ff @(posedge clk_in) begin
        if (i_rdy) begin
            if (state == FETCH_WAIT && i_ack) begin
                ir <= i_rdata;
            end
            if (state == EXEC) begin
                res <= i_alu_result;
            end
            if (state == MEM_WAIT && i_ack && is_load) begin
                res <= i_rdata;
            end
        end
    end

    // branch offsets and +4 keep fetches aligned
    a_pc_aligned: assert property (@(posedge clk_in) disable iff (!i_rst_n)
        pc[1:0] == 2'b00);

endmodule

`default_nettype wire

//--- hdl/mem_ctrl.sv
// memory controller, word requests to byte cycles
`timescale 1ns/1ps
`default_nettype none

module mem_ctrl (
    input  logic             clk_in,
    input  logic             i_rst_n,
    input  logic             i_rdy,
    // four-phase handshake from the sequencer
    input  logic             i_req,
    input  logic             i_we,
    input  mem_pkg::addr_t   i_addr,
    input  rv32_pkg::word_t  i_wdata,
    output logic             o_ack,
    output rv32_pkg::word_t  o_rdata,
    // byte bus, read data one cycle after the address
    input  mem_pkg::byte_t   i_mem_din,
    output mem_pkg::byte_t   o_mem_dout,
    output mem_pkg::addr_t   o_mem_a,
    output logic             o_mem_wr
);

    import rv32_pkg::*;
    import mem_pkg::*;

    // bytes issued so far, 0..4
    logic [2:0] cnt;
    // a read byte is due on i_mem_din
    logic       rd_pend;
    // lane of the byte that comes back
    logic [1:0] ret_idx;
    logic       issue;
    logic       last_wr;
    logic       last_rd;
    addr_t      byte_addr;

    // bytes still to go and the word not yet acked
    assign issue   = i_req && !o_ack && (cnt < 3'(BYTES_PER_WORD));
    assign last_wr = issue && i_we && (cnt == 3'(BYTES_PER_WORD - 1));
    // last read byte lands one cycle after its address
    assign last_rd = rd_pend && (cnt == 3'(BYTES_PER_WORD));
    assign ret_idx = cnt[1:0] - 2'd1;

    // word aligned, so the lane is just the count
    assign byte_addr  = {i_addr[31:2], cnt[1:0]};
    // ram plus i/o select bits, upper bits zero
    assign o_mem_a    = addr_t'(byte_addr[MEM_ADDR_BITS:0]);
    assign o_mem_dout = i_wdata[8*cnt[1:0] +: 8];
    assign o_mem_wr   = issue && i_we;

    always_ff @(posedge clk_in) begin
        if (!i_rst_n) begin
            cnt     <= '0;
            rd_pend <= 1'b0;
            o_ack   <= 1'b0;
        end else if (i_rdy) begin
            rd_pend <= issue && !i_we;
            if (!i_req) begin
                // req gone, close the handshake
                cnt   <= '0;
                o_ack <= 1'b0;
            end else begin
                if (issue) begin
                    cnt <= cnt + 3'd1;
                end
                if (last_wr || last_rd) begin
                    o_ack <= 1'b1;
                end
            end
        end
    end

    // assemble little-endian read word
    always_ff @(posedge clk_in) begin
        if (i_rdy && rd_pend) begin
            o_rdata[8*ret_idx +: 8] <= i_mem_din;
        end
    end

    // sequencer only asks for whole aligned words
    a_addr_aligned: assert property (@(posedge clk_in) disable iff (!i_rst_n)
        i_req |-> (i_addr[1:0] == 2'b00));

    // req must stay up until the word is acked
    a_req_held: assert property (@(posedge clk_in) disable iff (!i_rst_n)
        (i_req && !o_ack) |=> i_req);

endmodule

`default_nettype wire

//--- hdl/reg_file.sv
// integer register file, x0 reads zero
`timescale 1ns/1ps
`default_nettype none

module reg_file (
    input  logic               clk_in,
    input  logic               i_rst_n,
    input  logic               i_rdy,
    input  rv32_pkg::reg_idx_t i_rs1,
    input  rv32_pkg::reg_idx_t i_rs2,
    output rv32_pkg::word_t    o_rs1_val,
    output rv32_pkg::word_t    o_rs2_val,
    input  logic               i_we,
    input  rv32_pkg::reg_idx_t i_rd,
    input  rv32_pkg::word_t    i_wdata
);

    import rv32_pkg::*;

    // x1..x31, no storage for x0
    word_t regs [1:31];

    always_ff @(posedge clk_in) begin
        if (!i_rst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (i_rdy && i_we && (i_rd != '0)) begin
            regs[i_rd] <= i_wdata;
        end
    end

    // async read
    assign o_rs1_val = (i_rs1 == '0) ? '0 : regs[i_rs1];
    assign o_rs2_val = (i_rs2 == '0) ? '0 : regs[i_rs2];

endmodule

`default_nettype wire

//--- hdl/decoder.sv
// instruction decoder, fields, immediates and alu operation
`timescale 1ns/1ps
`default_nettype none

module decoder (
    input  rv32_pkg::word_t    i_inst,
    output rv32_pkg::opcode_t  o_opcode,
    output rv32_pkg::funct3_t  o_funct3,
    output rv32_pkg::reg_idx_t o_rd,
    output rv32_pkg::reg_idx_t o_rs1,
    output rv32_pkg::reg_idx_t o_rs2,
    output rv32_pkg::word_t    o_imm,
    output rv32_pkg::alu_op_e  o_alu_op,
    // alu takes the immediate instead of rs2
    output logic               o_use_imm
);

    import rv32_pkg::*;

    word_t   imm_i;
    word_t   imm_s;
    word_t   imm_b;
    word_t   imm_u;
    alu_op_e f3_op;

    assign o_opcode = i_inst[6:0];
    assign o_rd     = i_inst[11:7];
    assign o_funct3 = i_inst[14:12];
    assign o_rs1    = i_inst[19:15];
    assign o_rs2    = i_inst[24:20];

    // sign extended from bit 31
    assign imm_i = {{20{i_inst[31]}}, i_inst[31:20]};
    assign imm_s = {{20{i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
    assign imm_b = {{19{i_inst[31]}}, i_inst[31], i_inst[7], i_inst[30:25],
                    i_inst[11:8], 1'b0};
    assign imm_u = {i_inst[31:12], 12'b0};

    // funct3 to op, common to reg and imm forms
    always_comb begin
        case (o_funct3)
            F3_SLT:  f3_op = ALU_SLT;
            F3_XOR:  f3_op = ALU_XOR;
            F3_OR:   f3_op = ALU_OR;
            F3_AND:  f3_op = ALU_AND;
            default: f3_op = ALU_ADD;
        endcase
    end

    always_comb begin
        o_imm     = imm_i;
        o_alu_op  = ALU_ADD;
        o_use_imm = 1'b0;
        case (o_opcode)
            OPC_OP: begin
                // funct7 bit 5 picks sub
                if (o_funct3 == F3_ADD && i_inst[30]) begin
                    o_alu_op = ALU_SUB;
                end else begin
                    o_alu_op = f3_op;
                end
            end
            OPC_OP_IMM: begin
                o_alu_op  = f3_op;
                o_use_imm = 1'b1;
            end
            OPC_LUI: begin
                o_imm     = imm_u;
                o_alu_op  = ALU_PASS_B;
                o_use_imm = 1'b1;
            end
            // address generation
            OPC_LOAD: begin
                o_use_imm = 1'b1;
            end
            OPC_STORE: begin
                o_imm     = imm_s;
                o_use_imm = 1'b1;
            end
            // rs1 - rs2, zero flag decides
            OPC_BRANCH: begin
                o_imm    = imm_b;
                o_alu_op = ALU_SUB;
            end
            default: begin
                o_alu_op = ALU_ADD;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- hdl/alu.sv
// combinational alu with operand select and zero flag
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  rv32_pkg::alu_op_e i_op,
    input  rv32_pkg::word_t   i_a,
    input  rv32_pkg::word_t   i_b,
    input  rv32_pkg::word_t   i_imm,
    // immediate select from the decoder
    input  logic              i_use_imm,
    output rv32_pkg::word_t   o_result,
    // result is zero, branch compare
    output logic              o_zero
);

    import rv32_pkg::*;

    word_t b;

    assign b = i_use_imm ? i_imm : i_b;

    always_comb begin
        case (i_op)
            ALU_ADD:    o_result = i_a + b;
            ALU_SUB:    o_result = i_a - b;
            ALU_AND:    o_result = i_a & b;
            ALU_OR:     o_result = i_a | b;
            ALU_XOR:    o_result = i_a ^ b;
            // signed compare
            ALU_SLT:    o_result = word_t'($signed(i_a) < $signed(b));
            ALU_PASS_B: o_result = b;
            default:    o_result = '0;
        endcase
    end

    assign o_zero = (o_result == '0);

endmodule

`default_nettype wire

//--- hdl/mem_pkg.sv
// memory bus address and data types
// memory size and i/o address map constants
`default_nettype none

package mem_pkg;

    // byte address, only the low bits reach the memory
    typedef logic [31:0] addr_t;
    // one byte on the bus in each direction
    typedef logic [7:0]  byte_t;

    // 128 KB of ram behind the bus
    localparam int MEM_ADDR_BITS = 17;

    // addr[17:16] of an i/o access
    localparam logic [1:0] IO_SEL = 2'b11;

    // writing here ends the program
    localparam addr_t IO_STOP_ADDR = 32'h0003_0004;

    // little-endian word, one byte per bus cycle
    localparam int BYTES_PER_WORD = 4;

endpackage

`default_nettype wire

//--- hdl/rv32_pkg.sv
// rv32i field types, opcode and funct3 constants
// alu operation encoding
`default_nettype none

package rv32_pkg;

    // data path and instruction field widths
    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [6:0]  opcode_t;
    typedef logic [2:0]  funct3_t;

    // major opcodes of the supported subset
    localparam opcode_t OPC_OP     = 7'b0110011;
    localparam opcode_t OPC_OP_IMM = 7'b0010011;
    localparam opcode_t OPC_LUI    = 7'b0110111;
    localparam opcode_t OPC_LOAD   = 7'b0000011;
    localparam opcode_t OPC_STORE  = 7'b0100011;
    localparam opcode_t OPC_BRANCH = 7'b1100011;

    // funct3 of the alu group, shared by OP and OP-IMM
    localparam funct3_t F3_ADD = 3'b000;
    localparam funct3_t F3_SLT = 3'b010;
    localparam funct3_t F3_XOR = 3'b100;
    localparam funct3_t F3_OR  = 3'b110;
    localparam funct3_t F3_AND = 3'b111;
    // beq, anything else in the branch group is taken as bne
    localparam funct3_t F3_BEQ = 3'b000;

    // pass_b forwards the u immediate for lui
    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_PASS_B
    } alu_op_e;

endpackage

`default_nettype wire
